// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: design/load_align.sv
module load_align (
    input  lsu_pkg::data_t  rdata,
    input  logic [1:0]      offset,
    input  lsu_pkg::ld_op_t op,
    output lsu_pkg::data_t  data
);
    import lsu_pkg::*;

    data_t shifted;

    // bring the addressed byte down to lane 0
    always_comb begin
        case (offset)
            2'd0: shifted = rdata;
            2'd1: shifted = rdata >> 8;
            2'd2: shifted = rdata >> 16;
            default: shifted = rdata >> 24;
        endcase
    end

    // extend according to the load kind
    always_comb begin
        case (op)
            ld_lb: begin
                data = {{24{shifted[7]}}, shifted[7:0]};
            end
            ld_lbu: begin
                data = {24'h0, shifted[7:0]};
            end
            ld_lh: begin
                data = {{16{shifted[15]}}, shifted[15:0]};
            end
            ld_lhu: begin
                data = {16'h0, shifted[15:0]};
            end
            ld_lw: begin
                data = shifted;
            end
            default: begin
                data = '0;
            end
        endcase
    end

endmodule

// File: design/lsu.sv
module lsu (
    input  logic            clk,
    input  logic            rst,
    input  logic            ld_valid,
    input  lsu_pkg::ld_op_t ld_op,
    input  logic            st_valid,
    input  lsu_pkg::st_op_t st_op,
    input  lsu_pkg::addr_t  addr,
    input  lsu_pkg::data_t  st_data,
    output lsu_pkg::data_t  ld_data,
    output logic            ld_done,
    output logic            st_done,
    output logic            busy,
    output lsu_pkg::addr_t  araddr,
    output logic            arvalid,
    input  logic            arready,
    input  lsu_pkg::data_t  rdata,
    input  logic            rvalid,
    output logic            rready,
    output lsu_pkg::addr_t  awaddr,
    output logic            awvalid,
    input  logic            awready,
    output lsu_pkg::data_t  wdata,
    output lsu_pkg::strb_t  wstrb,
    output logic            wvalid,
    input  logic            wready,
    input  logic            bvalid,
    output logic            bready
);
    import lsu_pkg::*;

    lsu_state_t state;
    lsu_state_t state_next;

    // request captured at acceptance
    ld_op_t ld_op_q;
    st_op_t st_op_q;
    addr_t  addr_q;
    data_t  data_q;

    // write channels still waiting for their handshake
    logic aw_pend;
    logic w_pend;

    logic ld_start;
    logic st_start;
    logic aw_fire;
    logic w_fire;

    // loads win when both arrive together
    assign ld_start = (state == idle) && ld_valid && (ld_op != ld_none);
    assign st_start = (state == idle) && !ld_start && st_valid && (st_op != st_none);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (ld_start) begin
                    state_next = rd_addr;
                end else if (st_start) begin
                    state_next = wr_req;
                end
            end
            rd_addr: begin
                if (arready) begin
                    state_next = rd_data;
                end
            end
            rd_data: begin
                if (rvalid) begin
                    state_next = idle;
                end
            end
            wr_req: begin
                // aw and w may complete in different cycles
                if ((!aw_pend || aw_fire) && (!w_pend || w_fire)) begin
                    state_next = wr_resp;
                end
            end
            wr_resp: begin
                if (bvalid) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            state <= state_next;
            if (st_start) begin
                aw_pend <= 1'b1;
            end else if (aw_fire) begin
                aw_pend <= 1'b0;
            end
            if (st_start) begin
                w_pend <= 1'b1;
            end else if (w_fire) begin
                w_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_start || st_start) begin
            addr_q <= addr;
        end
        if (ld_start) begin
            ld_op_q <= ld_op;
        end
        if (st_start) begin
            st_op_q <= st_op;
            data_q  <= st_data;
        end
    end

    // replicate store data into every lane, strobe picks the live ones
    always_comb begin
        case (st_op_q)
            st_sb: begin
                wdata = {4{data_q[7:0]}};
                wstrb = 4'b0001 << addr_q[1:0];
            end
            st_sh: begin
                wdata = {2{data_q[15:0]}};
                wstrb = 4'b0011 << {addr_q[1], 1'b0};
            end
            st_sw: begin
                wdata = data_q;
                wstrb = 4'b1111;
            end
            default: begin
                wdata = data_q;
                wstrb = 4'b0000;
            end
        endcase
    end

    // valids come from state only, never from ready
    assign araddr  = addr_q;
    assign arvalid = (state == rd_addr);
    assign rready  = (state == rd_data);
    assign awaddr  = addr_q;
    assign awvalid = (state == wr_req) && aw_pend;
    assign wvalid  = (state == wr_req) && w_pend;
    assign bready  = (state == wr_resp);

    assign ld_done = rready && rvalid;
    assign st_done = bready && bvalid;
    assign busy    = (state != idle);

    load_align u_load_align (
        .rdata  (rdata),
        .offset (addr_q[1:0]),
        .op     (ld_op_q),
        .data   (ld_data)
    );

endmodule

// File: design/lsu_pkg.sv
package lsu_pkg;

    // bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // load kinds, 0 means no load
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_lb   = 3'd1,
        ld_lbu  = 3'd2,
        ld_lh   = 3'd3,
        ld_lhu  = 3'd4,
        ld_lw   = 3'd5
    } ld_op_t;

    // store kinds
    typedef enum logic [1:0] {
        st_none = 2'd0,
        st_sb   = 2'd1,
        st_sh   = 2'd2,
        st_sw   = 2'd3
    } st_op_t;

    // master fsm of the load/store unit
    typedef enum logic [2:0] {
        idle,
        rd_addr,
        rd_data,
        wr_req,
        wr_resp
    } lsu_state_t;

    // on-chip sram, word addressed by addr[9:2]
    localparam int sram_words = 256;
    typedef logic [7:0] sram_idx_t;

    // slave latency in cycles
    localparam int ar_delay = 3;
    localparam int r_delay  = 7;
    localparam int w_delay  = 2;

endpackage

// File: design/mem_stage.sv
module mem_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            ld_valid,
    input  lsu_pkg::ld_op_t ld_op,
    input  logic            st_valid,
    input  lsu_pkg::st_op_t st_op,
    input  lsu_pkg::addr_t  addr,
    input  lsu_pkg::data_t  st_data,
    output lsu_pkg::data_t  ld_data,
    output logic            ld_done,
    output logic            st_done,
    output logic            busy
);
    import lsu_pkg::*;

    // read channels
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    logic  rvalid;
    logic  rready;

    // write channels
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    logic  bvalid;
    logic  bready;

    lsu u_lsu (
        .clk      (clk),
        .rst      (rst),
        .ld_valid (ld_valid),
        .ld_op    (ld_op),
        .st_valid (st_valid),
        .st_op    (st_op),
        .addr     (addr),
        .st_data  (st_data),
        .ld_data  (ld_data),
        .ld_done  (ld_done),
        .st_done  (st_done),
        .busy     (busy),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rready   (rready),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

    sram_axi u_sram_axi (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// File: design/sram_axi.sv
module sram_axi (
    input  logic           clk,
    input  logic           rst,
    input  lsu_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output lsu_pkg::data_t rdata,
    output logic           rvalid,
    input  logic           rready,
    input  lsu_pkg::addr_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  lsu_pkg::data_t wdata,
    input  lsu_pkg::strb_t wstrb,
    input  logic           wvalid,
    output logic           wready,
    output logic           bvalid,
    input  logic           bready
);
    import lsu_pkg::*;

    data_t mem [0:sram_words-1];

    // latency counters, ready/valid shows up when the count hits zero
    logic       ar_wait;
    logic [3:0] ar_cnt;
    logic       r_wait;
    logic [3:0] r_cnt;
    logic       w_wait;
    logic [3:0] w_cnt;

    sram_idx_t rd_idx;
    sram_idx_t wr_idx;

    logic ar_fire;
    logic r_fire;
    logic wr_fire;

    assign arready = ar_wait && (ar_cnt == 4'd0);
    assign rvalid  = r_wait && (r_cnt == 4'd0);
    assign awready = w_wait && (w_cnt == 4'd0);
    assign wready  = w_wait && (w_cnt == 4'd0);

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    // aw and w are released together so both land in one cycle
    assign wr_fire = awvalid && awready && wvalid && wready;

    assign wr_idx = awaddr[9:2];
    assign rdata  = mem[rd_idx];

    // read address channel
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_wait <= 1'b0;
            ar_cnt  <= 4'd0;
        end else if (ar_fire) begin
            ar_wait <= 1'b0;
        end else if (arvalid && !ar_wait) begin
            ar_wait <= 1'b1;
            ar_cnt  <= 4'(ar_delay - 1);
        end else if (ar_cnt != 4'd0) begin
            ar_cnt <= ar_cnt - 4'd1;
        end
    end

    // read data channel, word index held from the address handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            r_wait <= 1'b0;
            r_cnt  <= 4'd0;
        end else if (ar_fire) begin
            r_wait <= 1'b1;
            r_cnt  <= 4'(r_delay - 1);
        end else if (r_fire) begin
            r_wait <= 1'b0;
        end else if (r_cnt != 4'd0) begin
            r_cnt <= r_cnt - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_idx <= araddr[9:2];
        end
    end

    // write address and data, wait until both valids are up
    always_ff @(posedge clk) begin
        if (rst) begin
            w_wait <= 1'b0;
            w_cnt  <= 4'd0;
        end else if (wr_fire) begin
            w_wait <= 1'b0;
        end else if (awvalid && wvalid && !w_wait && !bvalid) begin
            w_wait <= 1'b1;
            w_cnt  <= 4'(w_delay - 1);
        end else if (w_cnt != 4'd0) begin
            w_cnt <= w_cnt - 4'd1;
        end
    end

    // write response one cycle after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // byte lanes under strobe
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: sources.f
design/lsu_pkg.sv
design/load_align.sv
design/lsu.sv
design/sram_axi.sv
design/mem_stage.sv
tb/lsu_chk.sv
tb/mem_stage_tb.sv

// File: tb/lsu_chk.sv
module lsu_chk (
    input logic           clk,
    input logic           rst,
    input lsu_pkg::addr_t araddr,
    input logic           arvalid,
    input logic           arready,
    input logic           rvalid,
    input logic           rready,
    input lsu_pkg::addr_t awaddr,
    input logic           awvalid,
    input logic           awready,
    input lsu_pkg::data_t wdata,
    input lsu_pkg::strb_t wstrb,
    input logic           wvalid,
    input logic           wready,
    input logic           bvalid,
    input logic           bready,
    input logic           ld_done,
    input logic           st_done
);
    // failure count per property
    int unsigned ar_errs = 0;
    int unsigned r_errs = 0;
    int unsigned aw_errs = 0;
    int unsigned w_errs = 0;
    int unsigned b_errs = 0;
    int unsigned excl_errs = 0;
    int unsigned done_errs = 0;
    int unsigned errors;

    assign errors = ar_errs + r_errs + aw_errs + w_errs + b_errs + excl_errs + done_errs;

    // valid and payload held until the handshake
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            ar_errs++;
            $error("arvalid dropped or araddr changed before the handshake");
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else begin
            r_errs++;
            $error("rvalid dropped before the handshake");
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            aw_errs++;
            $error("awvalid dropped or awaddr changed before the handshake");
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            w_errs++;
            $error("wvalid dropped or write data changed before the handshake");
        end

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            b_errs++;
            $error("bvalid dropped before the handshake");
        end

    // one transaction at a time
    rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid))
        else begin
            excl_errs++;
            $error("arvalid and awvalid high together");
        end

    done_excl: assert property (@(posedge clk) disable iff (rst)
        !(ld_done && st_done))
        else begin
            done_errs++;
            $error("ld_done and st_done high together");
        end

endmodule

bind lsu lsu_chk u_lsu_chk (
    .clk     (clk),
    .rst     (rst),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .ld_done (ld_done),
    .st_done (st_done)
);

// File: tb/mem_stage_tb.sv
module mem_stage_tb;
    import lsu_pkg::*;

    localparam int timeout_cycles = 100;

    logic   clk;
    logic   rst;
    logic   ld_valid;
    ld_op_t ld_op;
    logic   st_valid;
    st_op_t st_op;
    addr_t  addr;
    data_t  st_data;
    data_t  ld_data;
    logic   ld_done;
    logic   st_done;
    logic   busy;

    // byte-wide copy of the sram, indexed by addr[9:0]
    logic [7:0] model [0:4*sram_words-1];

    mem_stage UUT (
        .clk      (clk),
        .rst      (rst),
        .ld_valid (ld_valid),
        .ld_op    (ld_op),
        .st_valid (st_valid),
        .st_op    (st_op),
        .addr     (addr),
        .st_data  (st_data),
        .ld_data  (ld_data),
        .ld_done  (ld_done),
        .st_done  (st_done),
        .busy     (busy)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %0t: %s, got %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic void model_store(input st_op_t op, input addr_t a, input data_t d);
        case (op)
            st_sb: begin
                model[a[9:0]] = d[7:0];
            end
            st_sh: begin
                model[{a[9:1], 1'b0}] = d[7:0];
                model[{a[9:1], 1'b1}] = d[15:8];
            end
            st_sw: begin
                for (int i = 0; i < 4; i++) begin
                    model[{a[9:2], 2'(i)}] = d[8*i +: 8];
                end
            end
            default: begin
            end
        endcase
    endfunction

    function automatic data_t model_word(input addr_t a);
        return {model[{a[9:2], 2'd3}], model[{a[9:2], 2'd2}],
                model[{a[9:2], 2'd1}], model[{a[9:2], 2'd0}]};
    endfunction

    // little endian byte and half picked straight from the model
    function automatic data_t expect_load(input ld_op_t op, input addr_t a);
        logic [7:0]  b;
        logic [15:0] h;
        b = model[a[9:0]];
        h = {model[{a[9:1], 1'b1}], model[{a[9:1], 1'b0}]};
        case (op)
            ld_lb:   return {{24{b[7]}}, b};
            ld_lbu:  return {24'h0, b};
            ld_lh:   return {{16{h[15]}}, h};
            ld_lhu:  return {16'h0, h};
            ld_lw:   return model_word(a);
            default: return '0;
        endcase
    endfunction

    task automatic start_load(input ld_op_t op, input addr_t a);
        ld_valid = 1'b1;
        ld_op    = op;
        addr     = a;
        @(posedge clk);
        #10;
        ld_valid = 1'b0;
        ld_op    = ld_none;
    endtask

    task automatic start_store(input st_op_t op, input addr_t a, input data_t d);
        st_valid = 1'b1;
        st_op    = op;
        addr     = a;
        st_data  = d;
        model_store(op, a, d);
        @(posedge clk);
        #10;
        st_valid = 1'b0;
        st_op    = st_none;
    endtask

    // busy must stay up until the done pulse
    task automatic wait_done(input logic is_load, output data_t data);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        data   = '0;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            check_flag(busy, 1'b1, "busy while a request is in flight");
            seen = is_load ? ld_done : st_done;
            if (seen && is_load) begin
                data = ld_data;
            end
            cycles++;
        end
        if (!seen && is_load) begin
            fail_run("ld_done never came within 100 cycles of the load request");
        end
        if (!seen && !is_load) begin
            fail_run("st_done never came within 100 cycles of the store request");
        end
        @(posedge clk);
        #10;
        check_flag(busy, 1'b0, "busy after the done pulse");
        check_flag(is_load ? ld_done : st_done, 1'b0, "done pulse longer than one cycle");
    endtask

    task automatic do_store(input st_op_t op, input addr_t a, input data_t d);
        data_t ignored;
        start_store(op, a, d);
        wait_done(1'b0, ignored);
    endtask

    task automatic do_load(input ld_op_t op, input addr_t a, output data_t data);
        start_load(op, a);
        wait_done(1'b1, data);
    endtask

    task automatic load_and_compare(input ld_op_t op, input addr_t a);
        data_t got;
        do_load(op, a, got);
        check_data(got, expect_load(op, a), $sformatf("%s at %h", op.name(), a));
    endtask

    task automatic test_reset;
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(ld_done, 1'b0, "ld_done after reset");
        check_flag(st_done, 1'b0, "st_done after reset");
    endtask

    task automatic test_word_round_trip;
        addr_t a [8];
        for (int i = 0; i < 8; i++) begin
            a[i] = addr_t'($urandom_range(sram_words - 1, 0)) << 2;
            do_store(st_sw, a[i], $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            load_and_compare(ld_lw, a[i]);
        end
    endtask

    task automatic test_byte_half;
        addr_t base;
        base = addr_t'($urandom_range(sram_words - 1, 0)) << 2;
        do_store(st_sw, base, $urandom);
        for (int off = 0; off < 4; off++) begin
            do_store(st_sb, base + addr_t'(off), $urandom);
            load_and_compare(ld_lw, base);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_store(st_sh, base + addr_t'(off), $urandom);
            load_and_compare(ld_lw, base);
        end
    endtask

    task automatic test_load_extension;
        addr_t base;
        data_t word;
        base = addr_t'($urandom_range(sram_words - 1, 0)) << 2;
        for (int pass = 0; pass < 2; pass++) begin
            // first pass with every sign bit set, then with all clear
            word = (pass == 0) ? ($urandom | 32'h8080_8080) : ($urandom & 32'h7f7f_7f7f);
            do_store(st_sw, base, word);
            for (int off = 0; off < 4; off++) begin
                load_and_compare(ld_lb, base + addr_t'(off));
                load_and_compare(ld_lbu, base + addr_t'(off));
                if (off % 2 == 0) begin
                    load_and_compare(ld_lh, base + addr_t'(off));
                    load_and_compare(ld_lhu, base + addr_t'(off));
                end
            end
        end
    endtask

    task automatic test_busy;
        addr_t a;
        addr_t b;
        data_t got;
        a = 32'h0000_0040;
        b = 32'h0000_0080;
        do_store(st_sw, b, $urandom);
        // second store while busy must be dropped
        start_store(st_sw, a, $urandom);
        check_flag(busy, 1'b1, "busy the cycle after a store request");
        st_valid = 1'b1;
        st_op    = st_sw;
        addr     = b;
        st_data  = ~model_word(b);
        @(posedge clk);
        #10;
        st_valid = 1'b0;
        st_op    = st_none;
        wait_done(1'b0, got);
        load_and_compare(ld_lw, b);
        load_and_compare(ld_lw, a);
        // second load while busy must be dropped
        start_load(ld_lw, a);
        check_flag(busy, 1'b1, "busy the cycle after a load request");
        ld_valid = 1'b1;
        ld_op    = ld_lb;
        addr     = b;
        @(posedge clk);
        #10;
        ld_valid = 1'b0;
        ld_op    = ld_none;
        wait_done(1'b1, got);
        check_data(got, model_word(a), "lw with a second request during busy");
        load_and_compare(ld_lhu, a + 32'd2);
    endtask

    initial begin
        void'($urandom(54751));
        clk      = 1'b0;
        rst      = 1'b1;
        ld_valid = 1'b0;
        ld_op    = ld_none;
        st_valid = 1'b0;
        st_op    = st_none;
        addr     = '0;
        st_data  = '0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        test_reset;
        test_word_round_trip;
        test_byte_half;
        test_load_extension;
        test_busy;
        if (UUT.u_lsu.u_lsu_chk.errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run("concurrent assertions on the AXI channels failed");
        end
    end

endmodule
